/* soc_bus_top.f */
+incdir+source
source/pi1_pkg.sv
source/serial_pkg.sv
source/pi1_if.sv
source/pi1_router.sv
source/smem.sv
source/serial_port.sv
source/soc_bus_top.sv
test/soc_bus_top_sva.sv
test/soc_bus_top_tb.sv

/* Makefile */
# Verilator build and run for the bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= soc_bus_top_tb
FLIST     ?= soc_bus_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Result: FAILED

SRCS := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a non-zero exit or the fail message in the log fails the run
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/soc_bus_top_tb.sv */
/*
 * testbench for the bus subsystem: clock, reset, LFSR data, bus tasks,
 * value check and directed tests for memory, invalid slave and serial port
 */
`default_nettype none

`include "soc_bus_defs.svh"

module soc_bus_top_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pi1_pkg::*;

	localparam int        PERIOD       = 40;
	localparam int        DEPTH        = `SOC_SERIAL_DEPTH;
	localparam int        CNTW         = $clog2(`SOC_SERIAL_DEPTH + 1);
	localparam int        RAM_WORDS    = `SOC_SMEM_WORDS;
	localparam int        BURST        = `SOC_SERIAL_DEPTH + 2;
	localparam int        BUS_TIMEOUT  = 400;
	localparam int        IDLE_CYCLES  = 12 * `SOC_BAUD_DIV;
	localparam int        LINE_TIMEOUT = 20000;
	localparam pi1_addr_t SER_DATA     = `SOC_SERIAL_BASE;
	localparam pi1_addr_t SER_STAT     = `SOC_SERIAL_BASE + 1;
	// memory sits at byte 0x1000
	localparam pi1_addr_t RAM_BASE     = 30'h400;

	logic      clk;
	logic      rst_n;
	pi1_op_e   op;
	pi1_addr_t addr;
	pi1_data_t wdata;
	pi1_sel_t  sel;
	pi1_data_t rdata;
	logic      rdy;
	// tx looped back to rx
	logic      line;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          tests;
	int          last_wait;
	logic        aborted;

	soc_bus_top uut (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.pi1_op_i    (op),
		.pi1_addr_i  (addr),
		.pi1_data_i  (wdata),
		.pi1_sel_i   (sel),
		.pi1_data_o  (rdata),
		.pi1_rdy_o   (rdy),
		.serial_rx_i (line),
		.serial_tx_o (line)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected word after a lane-selected write
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] lanes);
		logic [31:0] w;
		w = old_w;
		for (int l = 0; l < 4; l++) begin
			if (lanes[l]) begin
				w[8*l +: 8] = new_w[8*l +: 8];
			end
		end
		return w;
	endfunction

	// status layout, tx free lowest, then rx fill, busy, overrun
	function automatic logic [31:0] status_word(input int tx_free, input int rx_fill,
		input logic busy, input logic ovr);
		logic [31:0] w;
		w = '0;
		w[CNTW-1:0]      = CNTW'(tx_free);
		w[2*CNTW-1:CNTW] = CNTW'(rx_fill);
		w[2*CNTW]        = busy;
		w[2*CNTW+1]      = ovr;
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (aborted) begin
			return;
		end
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// one transfer, rdy sampled a quarter period before each rising edge
	task automatic bus_xfer(input pi1_op_e xop, input pi1_addr_t xaddr,
		input pi1_data_t xdata, input pi1_sel_t xsel, output pi1_data_t xrdata);
		xrdata    = '0;
		last_wait = 0;
		if (aborted) begin
			return;
		end
		@(negedge clk);
		op    = xop;
		addr  = xaddr;
		wdata = xdata;
		sel   = xsel;
		#(PERIOD / 4);
		while (!rdy && last_wait < BUS_TIMEOUT) begin
			@(negedge clk);
			#(PERIOD / 4);
			last_wait++;
		end
		if (!rdy) begin
			$display("bus %s at word %h got no rdy in %0d cycles", xop.name(), xaddr,
				BUS_TIMEOUT);
			aborted = 1'b1;
		end
		xrdata = rdata;
		// transfer completes on the rising edge in between
		@(negedge clk);
		op = PI1_OP_NONE;
	endtask

	task automatic bus_write(input pi1_addr_t a, input pi1_data_t d, input pi1_sel_t s);
		pi1_data_t unused;
		bus_xfer(PI1_OP_WRITE, a, d, s, unused);
	endtask

	task automatic bus_read(input pi1_addr_t a, output pi1_data_t d);
		bus_xfer(PI1_OP_READ, a, '0, 4'hF, d);
	endtask

	task automatic bus_swap(input pi1_addr_t a, input pi1_data_t d, input pi1_sel_t s,
		output pi1_data_t old_w);
		bus_xfer(PI1_OP_SWAP, a, d, s, old_w);
	endtask

	// line idle for longer than any run of ones inside a frame
	task automatic wait_line_idle();
		int high_run;
		int cycles;
		high_run = 0;
		cycles   = 0;
		while (high_run < IDLE_CYCLES && cycles < LINE_TIMEOUT && !aborted) begin
			@(negedge clk);
			high_run = (line === 1'b1) ? high_run + 1 : 0;
			cycles++;
		end
		if (high_run < IDLE_CYCLES && !aborted) begin
			$display("serial line still busy after %0d cycles", LINE_TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	// one frame off the line, bit 0 is the first bit sent
	task automatic capture_frame(output logic [9:0] frame);
		int cycles;
		frame  = '1;
		cycles = 0;
		while (line !== 1'b0 && cycles < LINE_TIMEOUT && !aborted) begin
			@(negedge clk);
			cycles++;
		end
		if (line !== 1'b0) begin
			if (!aborted) begin
				$display("no start bit on the serial line in %0d cycles", LINE_TIMEOUT);
				aborted = 1'b1;
			end
			return;
		end
		// half a bit into the start bit, then one bit per step
		repeat (`SOC_BAUD_DIV / 2) @(negedge clk);
		frame[0] = line;
		for (int b = 1; b < 10; b++) begin
			repeat (`SOC_BAUD_DIV) @(negedge clk);
			frame[b] = line;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("test %s finished with %0d errors%s", name, errors - err_before,
			aborted ? ", run aborted" : "");
	endtask

	task automatic test_mem_rw();
		pi1_data_t model [RAM_WORDS];
		int        idx_q [$];
		int        idx;
		pi1_data_t d;
		int        err0;
		err0 = errors;
		for (int i = 0; i < 16; i++) begin
			idx = int'(rand_bits(10));
			d   = rand_bits(32);
			bus_write(RAM_BASE + pi1_addr_t'(idx), d, 4'hF);
			check_value("ram write cycles", 32'(last_wait), 32'd1);
			model[idx] = d;
			idx_q.push_back(idx);
		end
		// repeated addresses expect the latest word
		foreach (idx_q[i]) begin
			bus_read(RAM_BASE + pi1_addr_t'(idx_q[i]), d);
			check_value("ram read cycles", 32'(last_wait), 32'd1);
			check_value("ram read data", d, model[idx_q[i]]);
		end
		end_test("mem_rw", err0);
	endtask

	task automatic test_sel_swap();
		pi1_addr_t a;
		pi1_data_t w0;
		pi1_data_t w1;
		pi1_data_t w2;
		pi1_data_t exp1;
		pi1_data_t d;
		int        err0;
		err0 = errors;
		a    = RAM_BASE + pi1_addr_t'(rand_bits(10));
		w0   = rand_bits(32);
		w1   = rand_bits(32);
		w2   = rand_bits(32);
		bus_write(a, w0, 4'hF);
		bus_write(a, w1, 4'b0101);
		exp1 = merge_lanes(w0, w1, 4'b0101);
		bus_read(a, d);
		check_value("partial write data", d, exp1);
		// swap hands back the merged word and stores the upper lanes
		bus_swap(a, w2, 4'b1100, d);
		check_value("swap old data", d, exp1);
		bus_read(a, d);
		check_value("after swap data", d, merge_lanes(exp1, w2, 4'b1100));
		end_test("sel_swap", err0);
	endtask

	task automatic test_invalid();
		pi1_addr_t bad [4];
		pi1_data_t keep;
		pi1_data_t d;
		int        err0;
		err0   = errors;
		bad[0] = 30'h0;
		bad[1] = SER_DATA - 1;
		bad[2] = RAM_BASE + pi1_addr_t'(RAM_WORDS);
		bad[3] = '1;
		keep   = rand_bits(32);
		bus_write(RAM_BASE, keep, 4'hF);
		foreach (bad[i]) begin
			bus_read(bad[i], d);
			check_value("invalid read data", d, 32'h0);
			check_value("invalid read cycles", 32'(last_wait), 32'd0);
		end
		// both addresses would alias word 0 without the decoder
		bus_write(bad[0], ~keep, 4'hF);
		check_value("invalid write cycles", 32'(last_wait), 32'd0);
		bus_write(bad[2], ~keep, 4'hF);
		bus_read(RAM_BASE, d);
		check_value("ram after invalid write", d, keep);
		end_test("invalid", err0);
	endtask

	task automatic test_loopback();
		logic [7:0] tx_bytes [4];
		logic [9:0] frame;
		pi1_data_t  d;
		int         err0;
		err0 = errors;
		check_value("serial_tx_o idle level", 32'(line), 32'd1);
		// first frame is watched on the line while the writes go on
		fork
			capture_frame(frame);
			foreach (tx_bytes[i]) begin
				tx_bytes[i] = 8'(rand_bits(8));
				bus_write(SER_DATA, {24'h0, tx_bytes[i]}, 4'b0001);
				check_value("serial write cycles", 32'(last_wait), 32'd1);
			end
		join
		check_value("serial_tx_o start bit", 32'(frame[0]), 32'd0);
		check_value("serial_tx_o data bits", 32'(frame[8:1]), 32'(tx_bytes[0]));
		check_value("serial_tx_o stop bit", 32'(frame[9]), 32'd1);
		wait_line_idle();
		bus_read(SER_STAT, d);
		check_value("rx fill after loopback", 32'(d[2*CNTW-1:CNTW]), 32'd4);
		foreach (tx_bytes[i]) begin
			bus_read(SER_DATA, d);
			check_value("rx word", d, {23'h0, 1'b1, tx_bytes[i]});
		end
		// nothing pending now
		bus_read(SER_DATA, d);
		check_value("rx valid when empty", 32'(d[8]), 32'd0);
		end_test("loopback", err0);
	endtask

	task automatic test_backpressure();
		logic [7:0] tx_bytes [BURST];
		pi1_data_t  d;
		int         err0;
		err0 = errors;
		// the shifter takes the first byte at once, so only the last write stalls
		for (int i = 0; i < BURST; i++) begin
			tx_bytes[i] = 8'(rand_bits(8));
			bus_write(SER_DATA, {24'h0, tx_bytes[i]}, 4'b0001);
			if (i < BURST - 1) begin
				check_value("burst write cycles", 32'(last_wait), 32'd1);
			end else begin
				check_value("last write stalled", 32'(last_wait > 1), 32'd1);
			end
		end
		bus_read(SER_STAT, d);
		check_value("tx free after burst", 32'(d[CNTW-1:0]), 32'd0);
		check_value("tx busy after burst", 32'(d[2*CNTW]), 32'd1);
		// receive FIFO fills up and the last two bytes are dropped
		wait_line_idle();
		bus_read(SER_STAT, d);
		check_value("status after overflow", d, status_word(DEPTH, DEPTH, 1'b0, 1'b1));
		bus_read(SER_STAT, d);
		check_value("status overrun cleared", d, status_word(DEPTH, DEPTH, 1'b0, 1'b0));
		for (int i = 0; i < DEPTH; i++) begin
			bus_read(SER_DATA, d);
			check_value("rx word after overflow", d, {23'h0, 1'b1, tx_bytes[i]});
		end
		bus_read(SER_DATA, d);
		check_value("rx valid after drain", 32'(d[8]), 32'd0);
		end_test("backpressure", err0);
	endtask

	initial begin
		op      = PI1_OP_NONE;
		addr    = '0;
		wdata   = '0;
		sel     = '0;
		rst_n   = 1'b0;
		lfsr    = 32'h2572_0636;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		aborted = 1'b0;
		// two rising edges in reset
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_mem_rw();
		test_sel_swap();
		test_invalid();
		test_loopback();
		test_backpressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !aborted) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/soc_bus_top_sva.sv */
/*
 * bus protocol assertions on the router, bound into pi1_router
 */
`default_nettype none

`include "soc_bus_defs.svh"

module soc_bus_top_sva (
	input wire logic               clk_i,
	input wire logic               rst_n_i,
	input wire pi1_pkg::pi1_op_e   op_i,
	input wire pi1_pkg::pi1_addr_t addr_i,
	input wire pi1_pkg::pi1_data_t data_w_i,
	input wire pi1_pkg::pi1_sel_t  sel_i,
	input wire logic               rdy_i,
	input wire logic               ram_rdy_i
);
	timeunit 1ns;
	timeprecision 100ps;
	import pi1_pkg::*;

	// master holds the whole request until the slave answers
	request_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(op_i != PI1_OP_NONE && !rdy_i) |=>
		($stable(op_i) && $stable(addr_i) && $stable(data_w_i) && $stable(sel_i)))
		else $error("bus request changed while rdy was low");

	// memory answers with a single-cycle pulse
	ram_rdy_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ram_rdy_i |=> !ram_rdy_i)
		else $error("memory rdy high for two cycles in a row");

	// default slave answers in the cycle of the request
	low_addr_at_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(op_i != PI1_OP_NONE && addr_i < `SOC_SERIAL_BASE) |-> rdy_i)
		else $error("request below the map base did not complete at once");

endmodule

bind pi1_router soc_bus_top_sva sva (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.op_i      (m.op),
	.addr_i    (m.addr),
	.data_w_i  (m.data_w),
	.sel_i     (m.sel),
	.rdy_i     (m.rdy),
	.ram_rdy_i (s_ram.rdy)
);

`default_nettype wire

/* source/soc_bus_top.sv */
/*
 * subsystem top: master port, router, memory and serial port
 */
`default_nettype none

module soc_bus_top (
	input wire logic                clk_i,
	input wire logic                rst_n_i,
	// bus master port, driven from outside
	input wire pi1_pkg::pi1_op_e    pi1_op_i,
	input wire pi1_pkg::pi1_addr_t  pi1_addr_i,
	input wire pi1_pkg::pi1_data_t  pi1_data_i,
	input wire pi1_pkg::pi1_sel_t   pi1_sel_i,
	output pi1_pkg::pi1_data_t      pi1_data_o,
	output logic                    pi1_rdy_o,
	// serial line
	input wire logic                serial_rx_i,
	output logic                    serial_tx_o
);

	pi1_if m_link ();
	pi1_if serial_link ();
	pi1_if ram_link ();

	assign m_link.op     = pi1_op_i;
	assign m_link.addr   = pi1_addr_i;
	assign m_link.data_w = pi1_data_i;
	assign m_link.sel    = pi1_sel_i;
	assign pi1_data_o    = m_link.data_r;
	assign pi1_rdy_o     = m_link.rdy;

	pi1_router router (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.m        (m_link.slave),
		.s_serial (serial_link.master),
		.s_ram    (ram_link.master)
	);

	// memory decoded from byte 0x1000
	smem smem (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.bus     (ram_link.slave)
	);

	serial_port serial (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.bus     (serial_link.slave),
		.rx_i    (serial_rx_i),
		.tx_o    (serial_tx_o)
	);

endmodule

`default_nettype wire

/* source/serial_port.sv */
/*
 * byte-serial port: transmit and receive FIFOs, baud-divided shifters,
 * data and status registers on the bus
 */
`default_nettype none

`include "soc_bus_defs.svh"

module serial_port (
	input wire logic clk_i,
	input wire logic rst_n_i,
	pi1_if.slave     bus,
	input wire logic rx_i,
	output logic     tx_o
);
	import pi1_pkg::*;
	import serial_pkg::*;

	localparam int DEPTH = `SOC_SERIAL_DEPTH;
	localparam int PTRW  = $clog2(DEPTH);
	localparam int BAUDW = $clog2(`SOC_BAUD_DIV);
	localparam int TXF   = 0;
	localparam int RXF   = 1;

	// fifo state, index TXF for transmit and RXF for receive
	logic [7:0]             fmem [2][DEPTH];
	logic [PTRW-1:0]        wr_ptr [2];
	logic [PTRW-1:0]        rd_ptr [2];
	logic [SERIAL_CNTW-1:0] cnt [2];
	logic [7:0]             din [2];
	logic                   push [2];
	logic                   pop [2];
	logic                   full [2];
	logic                   empty [2];

	serial_reg_e   reg_sel;
	serial_word_u  rd_word;
	serial_word_u  data_q;
	logic          is_rd;
	logic          is_wr;
	logic          tx_req;
	logic          accept;
	logic          stat_rd;
	logic          rdy_q;
	logic          overrun_q;

	logic             tx_busy_q;
	logic [9:0]       tx_sr_q;
	logic [BAUDW-1:0] tx_baud_q;
	logic [3:0]       tx_bit_q;
	logic             tx_tick;

	logic             rx_meta_q;
	logic             rx_sync_q;
	logic             rx_busy_q;
	logic [BAUDW-1:0] rx_baud_q;
	logic [3:0]       rx_bit_q;
	logic [7:0]       rx_sr_q;
	logic             rx_sample;
	logic             rx_stop_ok;

	for (genvar f = 0; f < 2; f++) begin : g_fifo
		assign full[f]  = (cnt[f] == SERIAL_CNTW'(DEPTH));
		assign empty[f] = (cnt[f] == '0);

		always_ff @(posedge clk_i) begin
			if (!rst_n_i) begin
				wr_ptr[f] <= '0;
				rd_ptr[f] <= '0;
				cnt[f]    <= '0;
			end else begin
				if (push[f]) begin
					wr_ptr[f] <= (wr_ptr[f] == PTRW'(DEPTH - 1)) ? '0 : wr_ptr[f] + 1'b1;
				end
				if (pop[f]) begin
					rd_ptr[f] <= (rd_ptr[f] == PTRW'(DEPTH - 1)) ? '0 : rd_ptr[f] + 1'b1;
				end
				if (push[f] && !pop[f]) begin
					cnt[f] <= cnt[f] + 1'b1;
				end else if (pop[f] && !push[f]) begin
					cnt[f] <= cnt[f] - 1'b1;
				end
			end
		end

		always_ff @(posedge clk_i) begin
			if (push[f]) begin
				fmem[f][wr_ptr[f]] <= din[f];
			end
		end
	end

	// bus side, address bit 0 picks data or status
	assign reg_sel = serial_reg_e'(bus.addr[0]);
	assign is_rd   = (bus.op == PI1_OP_READ) || (bus.op == PI1_OP_SWAP);
	assign is_wr   = (bus.op == PI1_OP_WRITE) || (bus.op == PI1_OP_SWAP);
	assign tx_req  = is_wr && (reg_sel == SERIAL_REG_DATA) && bus.sel[0];
	// a data write into a full transmit FIFO waits here
	assign accept  = (bus.op != PI1_OP_NONE) && !rdy_q && !(tx_req && full[TXF]);
	assign stat_rd = accept && is_rd && (reg_sel == SERIAL_REG_STATUS);

	assign push[TXF] = accept && tx_req;
	assign din[TXF]  = bus.data_w[7:0];
	assign pop[RXF]  = accept && is_rd && (reg_sel == SERIAL_REG_DATA) && !empty[RXF];

	always_comb begin
		rd_word = '0;
		if (reg_sel == SERIAL_REG_STATUS) begin
			rd_word.status.tx_free = SERIAL_CNTW'(DEPTH) - cnt[TXF];
			rd_word.status.rx_fill = cnt[RXF];
			rd_word.status.tx_busy = tx_busy_q;
			rd_word.status.overrun = overrun_q;
		end else begin
			rd_word.rx.valid = !empty[RXF];
			rd_word.rx.data  = fmem[RXF][rd_ptr[RXF]];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= accept;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			data_q <= rd_word;
		end
	end

	assign bus.data_r = data_q;
	assign bus.rdy    = rdy_q;
	assign bus.mapsz  = 2;

	// transmit shifter, frame is start, 8 data lsb first, stop
	assign tx_tick   = (tx_baud_q == BAUDW'(`SOC_BAUD_DIV - 1));
	assign pop[TXF]  = !tx_busy_q && !empty[TXF];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tx_busy_q <= 1'b0;
			tx_sr_q   <= '1;
			tx_baud_q <= '0;
			tx_bit_q  <= '0;
		end else if (!tx_busy_q) begin
			if (!empty[TXF]) begin
				tx_busy_q <= 1'b1;
				tx_sr_q   <= {1'b1, fmem[TXF][rd_ptr[TXF]], 1'b0};
				tx_baud_q <= '0;
				tx_bit_q  <= '0;
			end
		end else if (tx_tick) begin
			tx_baud_q <= '0;
			tx_sr_q   <= {1'b1, tx_sr_q[9:1]};
			tx_bit_q  <= tx_bit_q + 1'b1;
			// stop bit done
			if (tx_bit_q == 4'd9) begin
				tx_busy_q <= 1'b0;
			end
		end else begin
			tx_baud_q <= tx_baud_q + 1'b1;
		end
	end

	// line idles high since the shift register refills with ones
	assign tx_o = tx_sr_q[0];

	// receive shifter, samples at mid-bit after a two-flop sync
	assign rx_sample  = rx_busy_q && (rx_baud_q == '0);
	assign rx_stop_ok = rx_sample && (rx_bit_q == 4'd9) && rx_sync_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
			rx_busy_q <= 1'b0;
			rx_baud_q <= '0;
			rx_bit_q  <= '0;
		end else begin
			rx_meta_q <= rx_i;
			rx_sync_q <= rx_meta_q;
			if (!rx_busy_q) begin
				if (!rx_sync_q) begin
					// falling edge, wait half a bit to land mid start bit
					rx_busy_q <= 1'b1;
					rx_baud_q <= BAUDW'(`SOC_BAUD_DIV / 2 - 1);
					rx_bit_q  <= '0;
				end
			end else if (rx_sample) begin
				rx_baud_q <= BAUDW'(`SOC_BAUD_DIV - 1);
				rx_bit_q  <= rx_bit_q + 1'b1;
				// glitch on the start bit or end of frame
				if ((rx_bit_q == 4'd0 && rx_sync_q) || rx_bit_q == 4'd9) begin
					rx_busy_q <= 1'b0;
				end
			end else begin
				rx_baud_q <= rx_baud_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_sample && rx_bit_q != 4'd0 && rx_bit_q != 4'd9) begin
			rx_sr_q <= {rx_sync_q, rx_sr_q[7:1]};
		end
	end

	// full receive FIFO drops the byte
	assign push[RXF] = rx_stop_ok && !full[RXF];
	assign din[RXF]  = rx_sr_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			overrun_q <= 1'b0;
		end else if (rx_stop_ok && full[RXF]) begin
			overrun_q <= 1'b1;
		end else if (stat_rd) begin
			overrun_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/smem.sv */
/*
 * single-port word memory with byte-lane writes,
 * read, write and swap, one-cycle response
 */
`default_nettype none

`include "soc_bus_defs.svh"

module smem (
	input wire logic clk_i,
	input wire logic rst_n_i,
	pi1_if.slave     bus
);
	import pi1_pkg::*;

	localparam int AW    = $clog2(`SOC_SMEM_WORDS);
	localparam int LANES = `SOC_ARCHBITSZ / 8;

	pi1_data_t       mem [`SOC_SMEM_WORDS];
	pi1_data_t       data_q;
	logic            rdy_q;
	logic            accept;
	logic            wr_en;
	logic [AW-1:0]   widx;

	// take a new request only while no response is showing
	assign accept = (bus.op != PI1_OP_NONE) && !rdy_q;
	assign wr_en  = accept && (bus.op == PI1_OP_WRITE || bus.op == PI1_OP_SWAP);
	assign widx   = bus.addr[AW-1:0];

	// rdy is a single-cycle pulse after each accepted request
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= accept;
		end
	end

	always_ff @(posedge clk_i) begin
		// old word is captured for read and swap alike
		if (accept) begin
			data_q <= mem[widx];
		end
		for (int l = 0; l < LANES; l++) begin
			if (wr_en && bus.sel[l]) begin
				mem[widx][8*l +: 8] <= bus.data_w[8*l +: 8];
			end
		end
	end

	assign bus.data_r = data_q;
	assign bus.rdy    = rdy_q;
	assign bus.mapsz  = `SOC_SMEM_WORDS;

endmodule

`default_nettype wire

/* source/pi1_router.sv */
/*
 * single-master router: address decode, op steering, response mux
 * and the built-in default slave for invalid addresses
 */
`default_nettype none

`include "soc_bus_defs.svh"

module pi1_router (
	input wire logic clk_i,
	input wire logic rst_n_i,
	pi1_if.slave     m,
	pi1_if.master    s_serial,
	pi1_if.master    s_ram
);
	import pi1_pkg::*;

	pi1_addr_t  ram_base;
	pi1_addr_t  map_end;
	pi1_slave_e sel_idx;
	pi1_slave_e last_q;
	pi1_slave_e resp_idx;
	logic       in_flight_q;

	// slaves stack upward from the base, each one takes its own map size
	assign ram_base = `SOC_SERIAL_BASE + s_serial.mapsz;
	assign map_end  = ram_base + s_ram.mapsz;

	always_comb begin
		if (m.addr >= `SOC_SERIAL_BASE && m.addr < ram_base) begin
			sel_idx = PI1_SLV_SERIAL;
		end else if (m.addr >= ram_base && m.addr < map_end) begin
			sel_idx = PI1_SLV_RAM;
		end else begin
			// below the base or past the last slave
			sel_idx = PI1_SLV_INVALID;
		end
	end

	// op only reaches the selected slave
	assign s_serial.op = (sel_idx == PI1_SLV_SERIAL) ? m.op : PI1_OP_NONE;
	assign s_ram.op    = (sel_idx == PI1_SLV_RAM) ? m.op : PI1_OP_NONE;

	// slaves see addresses relative to their own base
	assign s_serial.addr = m.addr - `SOC_SERIAL_BASE;
	assign s_ram.addr    = m.addr - ram_base;

	assign s_serial.data_w = m.data_w;
	assign s_ram.data_w    = m.data_w;
	assign s_serial.sel    = m.sel;
	assign s_ram.sel       = m.sel;

	// whole decoded span seen from the master side
	assign m.mapsz = map_end;

	// remember which slave owns a transfer that is still waiting for rdy
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			in_flight_q <= 1'b0;
			last_q      <= PI1_SLV_INVALID;
		end else if (m.op != PI1_OP_NONE && !m.rdy) begin
			in_flight_q <= 1'b1;
			if (!in_flight_q) begin
				last_q <= sel_idx;
			end
		end else begin
			in_flight_q <= 1'b0;
		end
	end

	assign resp_idx = in_flight_q ? last_q : sel_idx;

	always_comb begin
		case (resp_idx)
			PI1_SLV_SERIAL: begin
				m.data_r = s_serial.data_r;
				m.rdy    = s_serial.rdy;
			end
			PI1_SLV_RAM: begin
				m.data_r = s_ram.data_r;
				m.rdy    = s_ram.rdy;
			end
			default: begin
				// default slave answers at once with zero data
				m.data_r = '0;
				m.rdy    = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/pi1_if.sv */
/*
 * one bus link between a master and a slave
 */
`default_nettype none

interface pi1_if;
	import pi1_pkg::*;

	pi1_op_e   op;
	pi1_addr_t addr;
	// write data toward the slave, read data back
	pi1_data_t data_w;
	pi1_data_t data_r;
	pi1_sel_t  sel;
	logic      rdy;
	// words decoded by the slave
	pi1_addr_t mapsz;

	modport master (
		output op, addr, data_w, sel,
		input  data_r, rdy, mapsz
	);

	modport slave (
		input  op, addr, data_w, sel,
		output data_r, rdy, mapsz
	);

endinterface

`default_nettype wire

/* source/serial_pkg.sv */
/*
 * serial port register types: offsets, receive word, status word
 * and the union that overlays them on one bus word
 */
`default_nettype none

`include "soc_bus_defs.svh"

package serial_pkg;

	// width of a FIFO fill count, holds 0 to depth
	localparam int SERIAL_CNTW = $clog2(`SOC_SERIAL_DEPTH + 1);

	typedef enum logic {
		SERIAL_REG_DATA   = 1'b0,
		SERIAL_REG_STATUS = 1'b1
	} serial_reg_e;

	// data register read, valid low when nothing was pending
	typedef struct packed {
		logic [`SOC_ARCHBITSZ-10:0] pad;
		logic                       valid;
		logic [7:0]                 data;
	} serial_rx_t;

	// overrun stays set until status is read
	typedef struct packed {
		logic [`SOC_ARCHBITSZ-3-2*SERIAL_CNTW:0] pad;
		logic                                    overrun;
		logic                                    tx_busy;
		logic [SERIAL_CNTW-1:0]                  rx_fill;
		logic [SERIAL_CNTW-1:0]                  tx_free;
	} serial_status_t;

	typedef union packed {
		serial_rx_t     rx;
		serial_status_t status;
	} serial_word_u;

endpackage

`default_nettype wire

/* source/pi1_pkg.sv */
/*
 * bus types: op codes, address, data and byte-select words,
 * slave indices of the router
 */
`default_nettype none

`include "soc_bus_defs.svh"

package pi1_pkg;

	// op codes, swap reads the old word then writes the new one
	typedef enum logic [1:0] {
		PI1_OP_NONE  = 2'b00,
		PI1_OP_WRITE = 2'b01,
		PI1_OP_READ  = 2'b10,
		PI1_OP_SWAP  = 2'b11
	} pi1_op_e;

	// word address, byte offset bits dropped
	typedef logic [`SOC_ARCHBITSZ-3:0] pi1_addr_t;

	typedef logic [`SOC_ARCHBITSZ-1:0] pi1_data_t;

	// one select bit per byte lane
	typedef logic [`SOC_ARCHBITSZ/8-1:0] pi1_sel_t;

	// slaves in map order, invalid catches everything else
	typedef enum logic [1:0] {
		PI1_SLV_SERIAL  = 2'd0,
		PI1_SLV_RAM     = 2'd1,
		PI1_SLV_INVALID = 2'd2
	} pi1_slave_e;

endpackage

`default_nettype wire

/* source/soc_bus_defs.svh */
/*
 * subsystem parameters: bus width, memory depth, serial FIFO depth,
 * baud divider and the base word address of the peripheral map
 */
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// data word width in bits
`define SOC_ARCHBITSZ 32

// on-chip memory depth in words, 4 KB
`define SOC_SMEM_WORDS 1024

// entries in each serial FIFO
`define SOC_SERIAL_DEPTH 8

// clock cycles per serial bit
`define SOC_BAUD_DIV 8

// word address of the first slave
// serial port has a map size of 2, so memory lands on byte 0x1000
`define SOC_SERIAL_BASE 30'h3FE

`endif
